// ==== src/rob_defs.svh ====
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// Number of reorder buffer slots and the width of a slot index
`define ROB_ENTRIES 16
`define ROB_IDX_W 4

// Most instructions that may retire together in one cycle
`define CMT_WIDTH 4

// Width of the checkpoint index carried by each entry
`define CKPT_W 2

// System instructions share one opcode and must retire at the end of a group
`define OPC_SYS 6'h3f

// Opcodes from this value up to one below OPC_SYS are reserved
`define OPC_ILLEGAL_LO 6'h30

`endif

// ==== src/rob_pkg.sv ====
`include "rob_defs.svh"

package rob_pkg;

	// Index of one reorder buffer slot
	typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

	// Register format of an instruction word
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [10:0] func;
	} alu_view_t;

	// System format, with the function select in place of the register fields
	typedef struct packed {
		logic [5:0]  opcode;
		logic [9:0]  sys_fn;
		logic [15:0] imm;
	} sys_view_t;

	// The same 32 bit word read in either format
	typedef union packed {
		alu_view_t alu;
		sys_view_t sys;
	} instr_word_u;

	// One reorder buffer slot
	typedef struct packed {
		logic              v;
		logic              done;
		logic              excv;
		logic              nan;
		logic              oddball;
		logic [`CKPT_W-1:0] cndx;
		// Destination register, or the system function for oddball entries
		logic [9:0]        tag_field;
	} rob_entry_t;

endpackage

// ==== src/rob_dispatch.sv ====
`include "rob_defs.svh"

// Decodes the dispatched instruction word once and builds the slot contents
// that the store writes at its tail. Everything here is combinational, so the
// entry lands in the array at the edge that follows the dispatch strobe
module rob_dispatch (
	input  logic                    disp_valid,
	input  rob_pkg::instr_word_u    disp_instr,
	input  logic [`CKPT_W-1:0]      disp_cndx,
	input  logic                    rob_full,
	output logic                    wr_en,
	output rob_pkg::rob_entry_t     wr_entry
);

	// The opcode sits in the same place in both formats
	logic [5:0] opcode;
	logic       is_sys;
	logic       is_illegal;

	assign opcode = disp_instr.sys.opcode;

	// The system opcode is the top of the reserved range, so test it first
	assign is_sys = (opcode == `OPC_SYS);
	assign is_illegal = !is_sys && (opcode >= `OPC_ILLEGAL_LO);

	// A strobe while the buffer is full is simply lost
	assign wr_en = disp_valid && !rob_full;

	// ======================================================================
	// Entry formation
	// ======================================================================

	always_comb begin
		wr_entry.v = 1'b1;
		wr_entry.nan = 1'b0;
		wr_entry.cndx = disp_cndx;

		// Oddball entries still wait for a completion like any other entry
		wr_entry.oddball = is_sys;

		// An illegal opcode never reaches an execution unit, so it is
		// written already finished and flagged as faulting
		wr_entry.done = is_illegal;
		wr_entry.excv = is_illegal;

		// System words keep their function select, the rest keep rd
		if (is_sys) begin
			wr_entry.tag_field = disp_instr.sys.sys_fn;
		end else begin
			wr_entry.tag_field = {5'd0, disp_instr.alu.rd};
		end
	end

endmodule

// ==== src/rob_store.sv ====
`include "rob_defs.svh"

// Holds the slot array with its head and tail pointers and an exact count of
// occupied slots. Entries are written at the tail, marked done by completions
// and released from the head by the group count of the commit logic
module rob_store (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic                                      wr_en,
	input  rob_pkg::rob_entry_t                       wr_entry,
	input  logic                                      cmp_valid,
	input  rob_pkg::rob_idx_t                         cmp_tag,
	input  logic                                      cmp_exc,
	input  logic                                      cmp_nan,
	input  logic [2:0]                                commit_n,
	output rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0]    entries,
	output rob_pkg::rob_idx_t                         head,
	output logic [`ROB_IDX_W:0]                       occupancy,
	output rob_pkg::rob_idx_t                         disp_tag,
	output logic                                      rob_full
);

	rob_pkg::rob_idx_t         tail;
	logic [`ROB_ENTRIES-1:0]   retire_mask;

	// One bit per slot that leaves the buffer this cycle
	always_comb begin
		retire_mask = '0;
		for (int k = 0; k < `CMT_WIDTH; k++) begin
			if (k < int'(commit_n)) begin
				retire_mask[rob_pkg::rob_idx_t'(head + k)] = 1'b1;
			end
		end
	end

	// ======================================================================
	// Slot array and pointers
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			occupancy <= '0;
			// Every slot starts out empty
			for (int i = 0; i < `ROB_ENTRIES; i++) begin
				entries[i].v <= 1'b0;
			end
		end else begin
			// A completion on an empty slot is stale and dropped
			if (cmp_valid && entries[cmp_tag].v) begin
				entries[cmp_tag].done <= 1'b1;
				entries[cmp_tag].excv <= cmp_exc;
				entries[cmp_tag].nan <= cmp_nan;
			end

			for (int i = 0; i < `ROB_ENTRIES; i++) begin
				if (retire_mask[i]) begin
					entries[i].v <= 1'b0;
				end
			end

			// The tail slot is free whenever wr_en can be high, so this
			// never lands on a slot that is retiring in the same cycle
			if (wr_en) begin
				entries[tail] <= wr_entry;
			end

			head <= head + rob_pkg::rob_idx_t'(commit_n);
			tail <= tail + rob_pkg::rob_idx_t'(wr_en);
			// Dispatch and retirement may overlap, so count the difference
			occupancy <= occupancy + (`ROB_IDX_W+1)'(wr_en) - (`ROB_IDX_W+1)'(commit_n);
		end
	end

	assign disp_tag = tail;
	assign rob_full = (occupancy == (`ROB_IDX_W+1)'(`ROB_ENTRIES));

endmodule

// ==== src/rob_commit_count.sv ====
`include "rob_defs.svh"

// Works out how many finished entries at the head can retire together and
// registers that group for the outside world
module rob_commit_count (
	input  logic                                      clk,
	input  logic                                      rst,
	input  rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0]    entries,
	input  rob_pkg::rob_idx_t                         head,
	input  logic [`ROB_IDX_W:0]                       occupancy,
	output logic [2:0]                                commit_n,
	output logic                                      cmt_valid,
	output logic [2:0]                                cmt_count,
	output rob_pkg::rob_idx_t                         cmt_head,
	output logic                                      cmt_exc
);

	rob_pkg::rob_entry_t  slot;
	logic                 chain;
	logic                 blocked;
	logic [1:0]           nan_cnt;
	logic                 last_exc;
	logic                 joins;

	// ======================================================================
	// Group count
	// ======================================================================

	// Walk the head slots in order. The first slot that fails ends the group,
	// even if later slots would pass on their own
	always_comb begin
		chain = 1'b1;
		blocked = 1'b0;
		nan_cnt = 2'd0;
		last_exc = 1'b0;
		commit_n = 3'd0;
		slot = entries[head];
		joins = 1'b0;
		for (int k = 0; k < `CMT_WIDTH; k++) begin
			slot = entries[rob_pkg::rob_idx_t'(head + k)];
			// Oddball and faulting entries close the group behind them.
			// The RAT takes one checkpoint per update, so cndx must match
			// the head. Two NaN results already in the group stop it
			joins = chain && (k < int'(occupancy)) && slot.v && slot.done &&
				!blocked && (slot.cndx == entries[head].cndx) && (nan_cnt < 2'd2);
			if (joins) begin
				commit_n = commit_n + 3'd1;
				blocked = slot.oddball || slot.excv;
				nan_cnt = nan_cnt + 2'(slot.nan);
				last_exc = slot.excv;
			end else begin
				chain = 1'b0;
			end
		end
	end

	// ======================================================================
	// Registered commit report
	// ======================================================================

	// These show the group one cycle after the state it was counted from,
	// in step with the head pointer moving in the store
	always_ff @(posedge clk) begin
		if (rst) begin
			cmt_valid <= 1'b0;
			cmt_count <= 3'd0;
			cmt_head <= '0;
			cmt_exc <= 1'b0;
		end else begin
			cmt_valid <= (commit_n != 3'd0);
			cmt_count <= commit_n;
			cmt_head <= head;
			cmt_exc <= last_exc;
		end
	end

endmodule

// ==== src/rob_commit_unit.sv ====
`include "rob_defs.svh"

// Retirement end of the core: dispatch decode, the slot store and the
// commit group counter
module rob_commit_unit (
	input  logic                   clk,
	input  logic                   rst,
	// Dispatch side
	input  logic                   disp_valid,
	input  logic [31:0]            disp_instr,
	input  logic [`CKPT_W-1:0]     disp_cndx,
	output rob_pkg::rob_idx_t      disp_tag,
	// Completion side
	input  logic                   cmp_valid,
	input  rob_pkg::rob_idx_t      cmp_tag,
	input  logic                   cmp_exc,
	input  logic                   cmp_nan,
	// Commit report
	output logic                   cmt_valid,
	output logic [2:0]             cmt_count,
	output rob_pkg::rob_idx_t      cmt_head,
	output logic                   cmt_exc,
	output logic                   rob_full
);

	logic                                      wr_en;
	rob_pkg::rob_entry_t                       wr_entry;
	rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0]    entries;
	rob_pkg::rob_idx_t                         head;
	logic [`ROB_IDX_W:0]                       occupancy;
	logic [2:0]                                commit_n;

	rob_dispatch i_dispatch (
		.disp_valid (disp_valid),
		.disp_instr (disp_instr),
		.disp_cndx  (disp_cndx),
		.rob_full   (rob_full),
		.wr_en      (wr_en),
		.wr_entry   (wr_entry)
	);

	rob_store i_store (
		.clk       (clk),
		.rst       (rst),
		.wr_en     (wr_en),
		.wr_entry  (wr_entry),
		.cmp_valid (cmp_valid),
		.cmp_tag   (cmp_tag),
		.cmp_exc   (cmp_exc),
		.cmp_nan   (cmp_nan),
		.commit_n  (commit_n),
		.entries   (entries),
		.head      (head),
		.occupancy (occupancy),
		.disp_tag  (disp_tag),
		.rob_full  (rob_full)
	);

	// The count feeds straight back to the store to move the head
	rob_commit_count i_commit_count (
		.clk       (clk),
		.rst       (rst),
		.entries   (entries),
		.head      (head),
		.occupancy (occupancy),
		.commit_n  (commit_n),
		.cmt_valid (cmt_valid),
		.cmt_count (cmt_count),
		.cmt_head  (cmt_head),
		.cmt_exc   (cmt_exc)
	);

endmodule

// ==== verification/rob_commit_unit_properties.sv ====
`include "rob_defs.svh"

// Concurrent checks on the commit report and the full flag of the top level
module rob_commit_unit_properties (
	input logic                  clk,
	input logic                  rst,
	input logic                  cmt_valid,
	input logic [2:0]            cmt_count,
	input logic                  cmt_exc,
	input logic                  rob_full,
	input logic [2:0]            commit_n,
	input logic [`ROB_IDX_W:0]   occupancy
);

	timeunit 1ns;
	timeprecision 1ns;

	// Number of failed properties, read back by the testbench
	int unsigned failures = 0;

	// A reported group holds at least one and at most CMT_WIDTH entries
	count_in_range: assert property (@(posedge clk) disable iff (rst)
		cmt_valid |-> (cmt_count >= 3'd1) && (cmt_count <= 3'(`CMT_WIDTH)))
	else begin
		failures++;
		$error("cmt_count is out of range while cmt_valid is high");
	end

	// A full buffer takes no dispatch, so a retirement must shrink the occupancy
	full_retire_shrinks: assert property (@(posedge clk) disable iff (rst)
		(rob_full && commit_n != 3'd0) |=> (occupancy != $past(occupancy)))
	else begin
		failures++;
		$error("Retirement from a full buffer left the occupancy unchanged");
	end

	// Outputs come out of reset low
	quiet_after_reset: assert property (@(posedge clk)
		rst |=> !cmt_valid && !cmt_exc && !rob_full)
	else begin
		failures++;
		$error("An output was high in the cycle after reset");
	end

endmodule

bind rob_commit_unit rob_commit_unit_properties i_properties (
	.clk       (clk),
	.rst       (rst),
	.cmt_valid (cmt_valid),
	.cmt_count (cmt_count),
	.cmt_exc   (cmt_exc),
	.rob_full  (rob_full),
	.commit_n  (commit_n),
	.occupancy (occupancy)
);

// ==== verification/rob_commit_unit_tb.sv ====
`include "rob_defs.svh"

module rob_commit_unit_tb;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLK_PERIOD = 100;
	localparam int PHASE_CYCLES = 160;
	// Roughly 1200 stimulus cycles plus margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic                 clk;
	logic                 rst;
	logic                 disp_valid;
	logic [31:0]          disp_instr;
	logic [`CKPT_W-1:0]   disp_cndx;
	rob_pkg::rob_idx_t    disp_tag;
	logic                 cmp_valid;
	rob_pkg::rob_idx_t    cmp_tag;
	logic                 cmp_exc;
	logic                 cmp_nan;
	logic                 cmt_valid;
	logic [2:0]           cmt_count;
	rob_pkg::rob_idx_t    cmt_head;
	logic                 cmt_exc;
	logic                 rob_full;

	// Model of the buffer with its pointers, updated at each rising edge
	rob_pkg::rob_entry_t  model [`ROB_ENTRIES];
	int                   m_head;
	int                   m_tail;
	int                   m_occ;
	// Commit report expected after the latest rising edge
	logic                 exp_valid;
	int                   exp_count;
	int                   exp_head;
	logic                 exp_exc;
	logic [31:0]          rng;
	int                   errors;
	int                   checks;
	int                   cycle_count;

	rob_commit_unit i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic roll_percent(output int value);
		rng = lcg_step(rng);
		value = int'(rng[30:16]) % 100;
	endtask

	// Group rule applied to the model: done entries in order from the head,
	// closed by an oddball or a fault, by a new checkpoint or by two NaNs
	function automatic int expected_group(output logic last_exc);
		int n;
		int nans;
		int slot;
		logic stop;
		n = 0;
		nans = 0;
		stop = 1'b0;
		last_exc = 1'b0;
		for (int k = 0; k < `CMT_WIDTH; k++) begin
			slot = (m_head + k) % `ROB_ENTRIES;
			if (!stop && k < m_occ && model[slot].done && nans < 2 &&
				model[slot].cndx == model[m_head].cndx) begin
				n++;
				nans += int'(model[slot].nan);
				last_exc = model[slot].excv;
				stop = model[slot].oddball || model[slot].excv;
			end else begin
				stop = 1'b1;
			end
		end
		return n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("error: %s is %0h, expected %0h", name, actual, expected);
		end
	endtask

	// Inputs are chosen from the model at the falling edge and driven at
	// the next rising edge. The percentages bias each phase
	task automatic run_phase(input int cycles, input int odd_pct, input int ill_pct,
		input int cndx_pct, input int nan_pct, input int exc_pct,
		input int disp_pct, input int cmp_pct);
		int r_opc;
		int r_cndx;
		int r_disp;
		int r_cmp;
		int r_exc;
		int r_nan;
		int start;
		int slot;
		logic found;
		logic [5:0] opc;
		rob_pkg::rob_idx_t tag;
		for (int c = 0; c < cycles; c++) begin
			@(negedge clk);
			roll_percent(r_opc);
			roll_percent(r_cndx);
			roll_percent(r_disp);
			roll_percent(r_cmp);
			roll_percent(r_exc);
			roll_percent(r_nan);
			roll_percent(start);
			rng = lcg_step(rng);
			if (r_opc < odd_pct) begin
				opc = `OPC_SYS;
			end else if (r_opc < odd_pct + ill_pct) begin
				opc = `OPC_ILLEGAL_LO + 6'(rng[23:20] % 4'd15);
			end else begin
				opc = rng[31:26] % 6'h30;
			end
			// Outstanding slot from a random start, not the one already on the bus
			found = 1'b0;
			tag = '0;
			for (int i = 0; i < `ROB_ENTRIES; i++) begin
				slot = (start + i) % `ROB_ENTRIES;
				if (!found && model[slot].v && !model[slot].done &&
					!(cmp_valid && int'(cmp_tag) == slot)) begin
					found = 1'b1;
					tag = rob_pkg::rob_idx_t'(slot);
				end
			end
			@(posedge clk);
			disp_valid <= (r_disp < disp_pct);
			disp_instr <= {opc, rng[25:0]};
			disp_cndx <= (r_cndx < cndx_pct) ? disp_cndx + `CKPT_W'(1) : disp_cndx;
			cmp_valid <= found && (r_cmp < cmp_pct);
			cmp_tag <= tag;
			cmp_exc <= (r_exc < exc_pct);
			cmp_nan <= (r_nan < nan_pct);
		end
	endtask

	// ======================================================================
	// Model update and compare
	// ======================================================================

	always @(posedge clk) begin
		int n;
		logic last_exc;
		logic [5:0] opc;
		cycle_count++;
		if (rst) begin
			for (int i = 0; i < `ROB_ENTRIES; i++) begin
				model[i] = '0;
			end
			m_head = 0;
			m_tail = 0;
			m_occ = 0;
			exp_valid = 1'b0;
		end else begin
			// The group is counted from the state before this edge
			n = expected_group(last_exc);
			exp_valid = (n != 0);
			exp_count = n;
			exp_head = m_head;
			exp_exc = last_exc;
			if (cmp_valid && model[cmp_tag].v) begin
				model[cmp_tag].done = 1'b1;
				model[cmp_tag].excv = cmp_exc;
				model[cmp_tag].nan = cmp_nan;
			end
			for (int k = 0; k < n; k++) begin
				model[(m_head + k) % `ROB_ENTRIES].v = 1'b0;
			end
			// A strobe into a full buffer is lost
			if (disp_valid && m_occ < `ROB_ENTRIES) begin
				opc = disp_instr[31:26];
				model[m_tail] = '0;
				model[m_tail].v = 1'b1;
				model[m_tail].oddball = (opc == `OPC_SYS);
				model[m_tail].done = (opc != `OPC_SYS) && (opc >= `OPC_ILLEGAL_LO);
				model[m_tail].excv = model[m_tail].done;
				model[m_tail].cndx = disp_cndx;
				m_tail = (m_tail + 1) % `ROB_ENTRIES;
				m_occ++;
			end
			m_head = (m_head + n) % `ROB_ENTRIES;
			m_occ = m_occ - n;
		end
	end

	always @(negedge clk) begin
		// The model only tracks the buffer once reset has been released
		if (!rst) begin
			check_value("cmt_valid", 32'(cmt_valid), 32'(exp_valid));
			if (exp_valid) begin
				check_value("cmt_count", 32'(cmt_count), exp_count);
				check_value("cmt_head", 32'(cmt_head), exp_head);
				check_value("cmt_exc", 32'(cmt_exc), 32'(exp_exc));
			end
			check_value("rob_full", 32'(rob_full), 32'(m_occ == `ROB_ENTRIES));
			check_value("disp_tag", 32'(disp_tag), m_tail);
		end
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	// ======================================================================
	// Stimulus phases
	// ======================================================================

	initial begin
		rob_pkg::rob_idx_t tag_when_full;
		rst = 1'b1;
		disp_valid = 1'b0;
		disp_instr = '0;
		disp_cndx = '0;
		cmp_valid = 1'b0;
		cmp_tag = '0;
		cmp_exc = 1'b0;
		cmp_nan = 1'b0;
		rng = 32'h70dc;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		// Plain ALU work, then oddballs, faults, checkpoints and NaNs
		run_phase(PHASE_CYCLES, 0, 0, 0, 0, 0, 60, 75);
		run_phase(PHASE_CYCLES, 40, 0, 0, 0, 0, 60, 75);
		run_phase(PHASE_CYCLES, 0, 25, 0, 0, 20, 60, 75);
		run_phase(PHASE_CYCLES, 0, 0, 35, 0, 0, 60, 75);
		run_phase(PHASE_CYCLES, 0, 0, 0, 60, 0, 60, 75);
		// Without completions the head stalls and the buffer fills
		run_phase(2 * `ROB_ENTRIES, 0, 0, 0, 0, 0, 100, 0);
		@(negedge clk);
		checks++;
		assert (rob_full) else begin
			errors++;
			$display("The buffer did not report full after dispatching without completions");
		end
		// The tail slot of the model while full, which dropped strobes must not move
		tag_when_full = rob_pkg::rob_idx_t'(m_tail);
		run_phase(3, 0, 0, 0, 0, 0, 100, 0);
		@(negedge clk);
		check_value("disp_tag", 32'(disp_tag), 32'(tag_when_full));
		// Retirement frees slots and dispatch resumes
		run_phase(2 * PHASE_CYCLES, 15, 10, 15, 30, 10, 60, 80);
		run_phase(60, 0, 0, 0, 0, 0, 0, 100);
		run_phase(4, 0, 0, 0, 0, 0, 0, 0);
		$display("Checks: %0d, errors: %0d, property failures: %0d",
			checks, errors, i_dut.i_properties.failures);
		if (errors == 0 && i_dut.i_properties.failures == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== rob_commit_unit.f ====
+incdir+src
src/rob_pkg.sv
src/rob_dispatch.sv
src/rob_store.sv
src/rob_commit_count.sv
src/rob_commit_unit.sv
verification/rob_commit_unit_properties.sv
verification/rob_commit_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the ROB commit unit testbench

VERILATOR ?= verilator
TOP       ?= rob_commit_unit_tb
FILELIST  ?= rob_commit_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
